// ==== source/huff_code_pkg.sv ====
// ####################
// Character, code and code-class types
// Code width constants and the escape prefix
// ####################

`default_nettype none

package huff_code_pkg;

    localparam int ASCII_W = 7;                 // 7-bit ASCII
    localparam int CODE_W  = 10;                // Widest code, escape case
    localparam int LEN_W   = 4;                 // Holds lengths 0 to 10
    localparam int ESC_W   = 3;                 // Escape prefix width

    // Escape codes are this prefix followed by the raw character
    localparam logic [ESC_W-1:0] ESC_PREFIX = 3'b111;

    typedef logic [ASCII_W-1:0] ascii_t;        // One input character

    // Code class, one per length group of the table
    typedef enum logic [1:0] {
        CLS_SHORT3 = 2'd0,                      // Space and e
        CLS_MID4   = 2'd1,                      // t a o i n s r h
        CLS_LONG5  = 2'd2,                      // l d c u
        CLS_ESCAPE = 2'd3                       // Everything else
    } code_class_e;

    // Coder result, 16 bits in total
    typedef struct packed {
        logic [CODE_W-1:0] bits;                // Right-aligned, upper bits zero
        logic [LEN_W-1:0]  len;                 // Number of valid code bits
        code_class_e       cls;                 // Group the code came from
    } huff_code_t;

endpackage

`default_nettype wire

// ==== source/tt_pins_pkg.sv ====
// ####################
// Named fields for the dedicated and bidirectional pins
// ####################

`default_nettype none

package tt_pins_pkg;

    localparam int PIN_W = 8;                   // Width of every pin bank

    // Dedicated inputs ui_in
    typedef struct packed {
        logic       load;                       // Bit 7, rising edge starts a character
        logic [6:0] ascii;                      // Bits 6..0, character to code
    } pin_in_t;

    // Bidirectional outputs uio_out
    typedef struct packed {
        logic       spare;                      // Bit 7, tied low
        logic [3:0] len;                        // Bits 6..3, code length
        logic       valid;                      // Bit 2, valid_out strobe
        logic [1:0] code_hi;                    // Bits 1..0, code bits 9..8
    } uio_out_t;

endpackage

`default_nettype wire

// ==== source/input_manager.sv ====
// ####################
// Input manager: load edge detect, capture, case fold
// ####################

`default_nettype none

module input_manager
    import huff_code_pkg::*;
#(
    parameter bit FOLD_CASE = 1'b1              // Fold A-Z onto a-z
) (
    input  wire         clk,
    input  wire         arst_n,
    input  wire ascii_t ascii,                  // Raw character from the pins
    input  wire         load,                   // Level, rising edge counts
    output ascii_t      ascii_data,             // Captured character
    output logic        valid                   // One-cycle strobe after capture
);

    // Load edge tracking
    typedef enum logic {
        IM_IDLE = 1'b0,                         // Waiting for load high
        IM_HELD = 1'b1                          // Load seen high, wait for low
    } im_state_e;

    localparam ascii_t UPPER_A  = 7'h41;        // 'A'
    localparam ascii_t UPPER_Z  = 7'h5A;        // 'Z'
    localparam ascii_t CASE_BIT = 7'h20;        // Upper to lower offset

    im_state_e state;
    logic      is_upper;
    logic      capture;
    ascii_t    folded;

    always_comb begin
        is_upper = (ascii >= UPPER_A) && (ascii <= UPPER_Z);
        folded   = (FOLD_CASE && is_upper) ? (ascii | CASE_BIT) : ascii;
    end

    assign capture = (state == IM_IDLE) && load;    // Rising edge of load

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IM_IDLE;
            valid <= 1'b0;
        end else begin
            valid <= capture;                   // High for the cycle after capture
            case (state)
                IM_IDLE: begin
                    if (load) begin
                        state <= IM_HELD;
                    end
                end
                IM_HELD: begin
                    if (!load) begin            // Released, re-arm
                        state <= IM_IDLE;
                    end
                end
                default: state <= IM_IDLE;
            endcase
        end
    end

    // Character register, only loaded on the edge
    always_ff @(posedge clk) begin
        if (capture) begin
            ascii_data <= folded;
        end
    end

endmodule

`default_nettype wire

// ==== source/huffman_table.sv ====
// ####################
// Fixed Huffman code table, character to code
// ####################

`default_nettype none

module huffman_table
    import huff_code_pkg::*;
(
    input  wire ascii_t ascii,                  // Folded character
    output huff_code_t  code                    // Code, length and class
);

    // Complete prefix-free table
    //   000 / 001 for the two commonest, 0100..1011 next eight,
    //   11000..11011 next four, 111 + 7 raw bits for the rest
    always_comb begin
        code = '0;
        case (ascii)
            7'h20: begin                        // Space
                code.bits = 10'b00_0000_0000;
                code.len  = 4'd3;
                code.cls  = CLS_SHORT3;
            end
            7'h65: begin                        // e
                code.bits = 10'b00_0000_0001;
                code.len  = 4'd3;
                code.cls  = CLS_SHORT3;
            end
            7'h74: begin                        // t
                code.bits = 10'b00_0000_0100;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h61: begin                        // a
                code.bits = 10'b00_0000_0101;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h6F: begin                        // o
                code.bits = 10'b00_0000_0110;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h69: begin                        // i
                code.bits = 10'b00_0000_0111;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h6E: begin                        // n
                code.bits = 10'b00_0000_1000;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h73: begin                        // s
                code.bits = 10'b00_0000_1001;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h72: begin                        // r
                code.bits = 10'b00_0000_1010;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h68: begin                        // h
                code.bits = 10'b00_0000_1011;
                code.len  = 4'd4;
                code.cls  = CLS_MID4;
            end
            7'h6C: begin                        // l
                code.bits = 10'b00_0001_1000;
                code.len  = 4'd5;
                code.cls  = CLS_LONG5;
            end
            7'h64: begin                        // d
                code.bits = 10'b00_0001_1001;
                code.len  = 4'd5;
                code.cls  = CLS_LONG5;
            end
            7'h63: begin                        // c
                code.bits = 10'b00_0001_1010;
                code.len  = 4'd5;
                code.cls  = CLS_LONG5;
            end
            7'h75: begin                        // u
                code.bits = 10'b00_0001_1011;
                code.len  = 4'd5;
                code.cls  = CLS_LONG5;
            end
            default: begin                      // Escape, prefix then raw char
                code.bits = {ESC_PREFIX, ascii};
                code.len  = LEN_W'(CODE_W);
                code.cls  = CLS_ESCAPE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/huffman_coder.sv ====
// ####################
// Registered coder stage around the code table
// ####################

`default_nettype none

module huffman_coder
    import huff_code_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire ascii_t ascii_data,             // Character from input manager
    input  wire         valid,                  // Capture strobe
    output huff_code_t  code,                   // Held until next character
    output logic        valid_out               // One-cycle result strobe
);

    huff_code_t table_code;                     // Combinational lookup result

    // Lookup is purely combinational, the register below adds the one cycle
    huffman_table i_table (
        .ascii (ascii_data),
        .code  (table_code)
    );

    // valid_out copies valid one cycle later, so a single-cycle valid
    // always gives a single-cycle valid_out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid;
        end
    end

    // Outputs are visible on the pins, so they come up zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            code <= '0;                         // bits, len zero, class short3
        end else if (valid) begin
            code <= table_code;                 // Latch new code
        end
    end

endmodule

`default_nettype wire

// ==== source/tt_um_huffman_coder.sv ====
// ####################
// Top level: pin decode, input manager and coder
// ####################

`default_nettype none

module tt_um_huffman_coder
    import huff_code_pkg::*, tt_pins_pkg::*;
(
    input  wire  [PIN_W-1:0] ui_in,             // load and character
    output logic [PIN_W-1:0] uo_out,            // Code bits 7..0
    input  wire  [PIN_W-1:0] uio_in,            // Not used, bank is all outputs
    output logic [PIN_W-1:0] uio_out,           // Code high bits, strobe, length
    output logic [PIN_W-1:0] uio_oe,            // Output enables
    input  wire              ena,               // Always high when powered
    input  wire              clk,
    input  wire              arst_n
);

    localparam bit FOLD_CASE_EN = 1'b1;         // Capitals share lower-case codes

    pin_in_t    pins;                           // Named view of ui_in
    uio_out_t   uio_fields;                     // Named view of uio_out
    ascii_t     ascii_data;
    logic       valid;
    huff_code_t code;
    logic       valid_out;

    assign pins = pin_in_t'(ui_in);

    input_manager #(
        .FOLD_CASE (FOLD_CASE_EN)
    ) i_input_manager (
        .clk        (clk),
        .arst_n     (arst_n),
        .ascii      (pins.ascii),
        .load       (pins.load),
        .ascii_data (ascii_data),
        .valid      (valid)
    );

    huffman_coder i_huffman_coder (
        .clk        (clk),
        .arst_n     (arst_n),
        .ascii_data (ascii_data),
        .valid      (valid),
        .code       (code),
        .valid_out  (valid_out)
    );

    always_comb begin
        uio_fields.spare   = 1'b0;
        uio_fields.len     = code.len;
        uio_fields.valid   = valid_out;
        uio_fields.code_hi = code.bits[CODE_W-1:8];
    end

    assign uo_out  = code.bits[7:0];            // Low byte of the code
    assign uio_out = uio_fields;
    assign uio_oe  = '1;                        // Whole bank driven

endmodule

`default_nettype wire

// ==== dv/huffman_coder_properties.sv ====
// ####################
// Strobe and held-output assertions for the coder
// ####################

`default_nettype none

module huffman_coder_properties
    import huff_code_pkg::*;
(
    input wire             clk,
    input wire             arst_n,
    input wire             valid,               // Strobe from input manager
    input wire             valid_out,           // Result strobe
    input wire huff_code_t code                 // Registered code
);

    // Result strobe is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out |=> !valid_out)
        else $error("valid_out high for two cycles in a row");

    // One cycle from valid to valid_out in both directions
    a_follows_valid: assert property (@(posedge clk) disable iff (!arst_n)
        valid |=> valid_out)
        else $error("valid_out missing one cycle after valid");

    a_only_after_valid: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out |-> $past(valid))
        else $error("valid_out without valid one cycle before");

    // Length is zero after reset or a real code length
    a_len_range: assert property (@(posedge clk) disable iff (!arst_n)
        (code.len == 4'd0) || ((code.len >= 4'd3) && (code.len <= 4'd10)))
        else $error("code length out of range");

    // No new code unless the strobe says so
    a_code_held: assert property (@(posedge clk) disable iff (!arst_n)
        !valid_out |-> $stable(code))
        else $error("code changed while valid_out low");

endmodule

bind huffman_coder huffman_coder_properties i_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (valid),
    .valid_out (valid_out),
    .code      (code)
);

`default_nettype wire

// ==== dv/tb_huffman_coder.sv ====
// ####################
// Directed testbench with reference code model, checks and tests
// ####################

`default_nettype none

module tb_huffman_coder;
    import tt_pins_pkg::*;

    localparam int    HALF_PERIOD = 20;         // 40 unit clock
    localparam int    DRIVE_DLY   = 5;          // Inputs change after the edge
    localparam int    SAMPLE_DLY  = 1;          // Outputs settled by then
    localparam int    TIMEOUT     = 20;         // Cycles to wait for valid_out
    localparam int    SEED        = 32'h819d_c84e;
    localparam string SHORT3      = " e";       // 000, 001
    localparam string MID4        = "taoinsrh"; // 0100 upward
    localparam string LONG5       = "ldcu";     // 11000 upward

    logic       clk;
    logic       arst_n;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic       ena;
    wire  [7:0] uo_out;
    wire  [7:0] uio_out;
    wire  [7:0] uio_oe;
    uio_out_t   uio_f;                          // Named view of uio_out

    assign uio_f = uio_out;

    tt_um_huffman_coder i_dut (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .arst_n  (arst_n)
    );

    always #HALF_PERIOD clk = ~clk;

    // Expected {bits[9:0], len[3:0]} with capitals folded first
    function automatic logic [13:0] ref_code(input logic [6:0] ch);
        logic [6:0]  c;
        logic [13:0] res;
        c = ch;
        if ((c >= 7'h41) && (c <= 7'h5A)) begin
            c = c + 7'h20;                      // A-Z to a-z
        end
        res = {3'b111, c, 4'd10};               // Escape unless found below
        for (int i = 0; i < SHORT3.len(); i++) begin
            if (SHORT3[i] == {1'b0, c}) res = {10'(i), 4'd3};
        end
        for (int i = 0; i < MID4.len(); i++) begin
            if (MID4[i] == {1'b0, c}) res = {10'(4 + i), 4'd4};
        end
        for (int i = 0; i < LONG5.len(); i++) begin
            if (LONG5[i] == {1'b0, c}) res = {10'(24 + i), 4'd5};
        end
        return res;
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", test, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Edges to valid_out counted from the edge that samples load
    task automatic wait_valid_out(input string test, output int cycles);
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && (n < TIMEOUT)) begin
            @(posedge clk);
            #SAMPLE_DLY;
            n++;
            seen = uio_f.valid;
        end
        if (!seen) begin
            $display("valid_out never rose within %0d cycles in %s", TIMEOUT, test);
            $display("Something failed");
            $fatal(1);
        end
        cycles = n;
    endtask

    task automatic check_code(input string test, input logic [6:0] ch);
        logic [13:0] exp;
        exp = ref_code(ch);
        check_value({test, " bits"}, exp[13:4], {uio_f.code_hi, uo_out});
        check_value({test, " len"}, exp[3:0], uio_f.len);
        check_value({test, " spare"}, 0, uio_f.spare);
    endtask

    // One load pulse with latency and code checks before release
    task automatic code_char(input string test, input logic [6:0] ch);
        int cycles;
        @(posedge clk);
        #DRIVE_DLY;
        ui_in = {1'b1, ch};
        wait_valid_out(test, cycles);
        check_value({test, " latency"}, 2, cycles);
        check_code(test, ch);
        #(DRIVE_DLY - SAMPLE_DLY);
        ui_in = {1'b0, ch};                     // Release re-arms the next edge
        @(posedge clk);
        #SAMPLE_DLY;
        check_value({test, " strobe width"}, 0, uio_f.valid);
        check_code({test, " held"}, ch);
    endtask

    task automatic test_reset();
        check_value("reset uo_out", 0, uo_out);
        check_value("reset uio_out", 0, uio_out);
        check_value("reset len", 0, uio_f.len);
        check_value("reset valid_out", 0, uio_f.valid);
        check_value("reset uio_oe", 8'hFF, uio_oe);
    endtask

    task automatic test_table();
        string chars;
        byte   ch;
        chars = {SHORT3, MID4, LONG5};          // All 14 table entries
        for (int i = 0; i < chars.len(); i++) begin
            ch = chars[i];
            code_char($sformatf("table '%c'", ch), ch[6:0]);
        end
    endtask

    task automatic test_escape();
        string       fixed;
        byte         fc;
        logic [6:0]  ch;
        logic [13:0] exp;
        fixed = "0123456789!?.,;#";
        for (int i = 0; i < fixed.len(); i++) begin
            fc = fixed[i];
            code_char($sformatf("escape '%c'", fc), fc[6:0]);
        end
        for (int i = 0; i < 20; i++) begin
            ch = 7'($urandom);
            exp = ref_code(ch);
            for (int t = 0; (t < 50) && (exp[3:0] != 4'd10); t++) begin
                ch = 7'($urandom);              // Redraw table characters
                exp = ref_code(ch);
            end
            code_char($sformatf("escape rand %0h", ch), ch);
        end
    endtask

    task automatic test_case_fold();
        string caps;
        byte   ch;
        caps = "ETLSAUHQ";                      // Q folds to an escape of q
        for (int i = 0; i < caps.len(); i++) begin
            ch = caps[i];
            code_char($sformatf("fold '%c'", ch), ch[6:0]);
        end
    endtask

    task automatic test_edge();
        int cycles;
        @(posedge clk);
        #DRIVE_DLY;
        ui_in = {1'b1, 7'h61};                  // 'a' with load kept high
        wait_valid_out("edge hold", cycles);
        check_value("edge hold latency", 2, cycles);
        check_code("edge hold", 7'h61);
        repeat (6) begin
            @(posedge clk);
            #SAMPLE_DLY;
            check_value("edge hold strobe", 0, uio_f.valid);
            check_code("edge hold code", 7'h61);
            #(DRIVE_DLY - SAMPLE_DLY);
            ui_in = {1'b1, 7'h6E};              // New char without a new edge
        end
        ui_in = {1'b0, 7'h6E};
        @(posedge clk);
        #SAMPLE_DLY;
        check_code("edge released", 7'h61);     // Still the old code
        code_char("edge new", 7'h6E);
    endtask

    initial begin
        void'($urandom(SEED));
        clk    = 1'b0;
        arst_n = 1'b0;
        ui_in  = 8'h00;
        uio_in = 8'h00;
        ena    = 1'b1;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        test_reset();
        test_table();
        test_escape();
        test_case_fold();
        test_edge();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/huff_code_pkg.sv
source/tt_pins_pkg.sv
source/input_manager.sv
source/huffman_table.sv
source/huffman_coder.sv
source/tt_um_huffman_coder.sv
dv/huffman_coder_properties.sv
dv/tb_huffman_coder.sv
